// ==== src/dps_consts.svh ====
// DDR port selector constants
// Channel count and field widths shared by the selector RTL and its types

`ifndef DPS_CONSTS_SVH
`define DPS_CONSTS_SVH

//----------------------------------------------------------------------------
// Channel setup
//----------------------------------------------------------------------------
`define DPS_NUM_CH  4     // Front ends fa04 to fa07
`define DPS_SEL_W   2     // Channel index width

//----------------------------------------------------------------------------
// DDR command fields
//----------------------------------------------------------------------------
`define DPS_ADDR_W  27    // DDR start address
`define DPS_AREA_W  4     // Acoustic data area select
`define DPS_SIZE_W  32    // Access size in bytes

//----------------------------------------------------------------------------
// Avalon-ST payload
//----------------------------------------------------------------------------
`define DPS_DATA_W  128   // Write and read data bus

`endif

// ==== src/dps_pkg.sv ====
// DDR port selector types
// Records for one DDR access request, one Avalon-ST beat and the decoded
// channel selection. Widths come from the constants header.

`include "dps_consts.svh"

package dps_pkg;

    //------------------------------------------------------------------------
    // DDR access request, 65 bits
    //------------------------------------------------------------------------
    typedef struct packed {
        logic                   wxr;    // Write when high, read when low
        logic [`DPS_AREA_W-1:0] area;   // Area select
        logic [`DPS_ADDR_W-1:0] addr;   // Start address
        logic [`DPS_SIZE_W-1:0] size;   // Byte count
        logic                   start;  // Access start pulse
    } ddr_cmd_t;

    //------------------------------------------------------------------------
    // Avalon-ST beat, 133 bits
    //------------------------------------------------------------------------
    // Same layout for the write path toward DDR and the read path back
    typedef struct packed {
        logic                   sop;    // Packet start
        logic                   eop;    // Packet end
        logic                   valid;  // Beat valid
        logic                   first;  // First beat of access
        logic                   last;   // Last beat of access
        logic [`DPS_DATA_W-1:0] data;   // Payload
    } st_beat_t;

    //------------------------------------------------------------------------
    // Decoded channel selection, 3 bits
    //------------------------------------------------------------------------
    typedef struct packed {
        logic [`DPS_SEL_W-1:0]  idx;    // Selected channel
        logic                   hit;    // Exactly one enable set
    } ch_sel_t;

endpackage

// ==== src/chan_sel.sv ====
// Channel enable decoder
// Turns the one-hot front-end enable into a channel index and a hit flag.
// An enable with no bit or several bits set gives no hit and index zero.

`include "dps_consts.svh"

module chan_sel
    import dps_pkg::*;
(
    input  logic [`DPS_NUM_CH-1:0] i_fa_en,   // Front-end enable, bit 0 is fa04
    output ch_sel_t                o_sel      // Decoded selection
);

    localparam int SEL_W = `DPS_SEL_W;
    localparam int CNT_W = $clog2(`DPS_NUM_CH + 1);

    logic [CNT_W-1:0] en_cnt;  // Enable bits set
    logic [SEL_W-1:0] en_pos;  // Highest set bit

    //------------------------------------------------------------------------
    // Population count and position, purely combinational
    //------------------------------------------------------------------------
    always_comb begin
        en_cnt = '0;
        en_pos = '0;
        for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
            if (i_fa_en[ch]) begin
                en_cnt = en_cnt + 1'b1;       // Count set bits
                en_pos = SEL_W'(ch);          // Keep last set position
            end
        end

        o_sel.hit = (en_cnt == CNT_W'(1));               // One bit only
        o_sel.idx = o_sel.hit ? en_pos : '0;             // Park at zero

        // Counter result cross-checked against the one-hot builtin
        a_hit_onehot : assert (!o_sel.hit || $onehot(i_fa_en))
            else $error("chan_sel hit with enable %h", i_fa_en);
    end

endmodule

// ==== src/chan_mux.sv ====
// Registered channel multiplexer
// Picks one front end's payload by the decoded selection and registers it
// toward the DDR port. No hit registers an all-zero payload.
// The payload type is a parameter, so one block serves command, write beat
// and read-ready.

`include "dps_consts.svh"

module chan_mux
    import dps_pkg::*;
#(
    parameter type T = logic                      // Payload per channel
) (
    input  logic                  i_arst,         // Clock
    input  logic                  i_clk156m,      // Async reset, active high
    input  ch_sel_t               i_sel,          // Decoded channel
    input  T [`DPS_NUM_CH-1:0]    i_ch,           // Payload of each front end
    output T                      o_q             // Registered selection
);

    //------------------------------------------------------------------------
    // Select and register
    //------------------------------------------------------------------------
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_q <= '0;                            // Start bits low after reset
        end else if (i_sel.hit) begin
            o_q <= i_ch[i_sel.idx];               // Enabled channel
        end else begin
            o_q <= '0;                            // Nothing enabled
        end
    end

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------
    // Guards the index width against a channel count that is not a power of 2
    a_idx_range : assert property (
        @(posedge i_arst) disable iff (i_clk156m)
        i_sel.hit |-> (i_sel.idx < `DPS_NUM_CH)
    ) else $error("chan_mux index %0d out of range", i_sel.idx);

endmodule

// ==== src/resp_demux.sv ====
// DDR response fan-out
// Registers the DDR port's responses toward the four front ends.
// Access-complete, write-ready and read valid/first/last reach only the
// selected channel. Read sop, eop and data go to every channel.

`include "dps_consts.svh"

module resp_demux
    import dps_pkg::*;
(
    input  logic                            i_arst,       // Clock
    input  logic                            i_clk156m,    // Async reset, active high
    input  ch_sel_t                         i_sel,        // Decoded channel
    input  logic                            i_endp,       // DDR access complete
    input  logic                            i_wr_ready,   // DDR write FIFO ready
    input  st_beat_t                        i_rd,         // DDR read beat
    output logic     [`DPS_NUM_CH-1:0]      o_endp,       // Complete per channel
    output logic     [`DPS_NUM_CH-1:0]      o_wr_ready,   // Write ready per channel
    output st_beat_t [`DPS_NUM_CH-1:0]      o_rd          // Read beat per channel
);

    logic [`DPS_NUM_CH-1:0] ch_mask;    // One-hot target, zero on miss
    logic [`DPS_NUM_CH-1:0] rd_valid;   // Delivered valids, for checking

    //------------------------------------------------------------------------
    // Target channel mask
    //------------------------------------------------------------------------
    always_comb begin
        ch_mask = '0;
        if (i_sel.hit) begin
            ch_mask[i_sel.idx] = 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Response registers
    //------------------------------------------------------------------------
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_endp     <= '0;
            o_wr_ready <= '0;
            o_rd       <= '0;
        end else begin
            for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
                o_endp[ch]      <= ch_mask[ch] & i_endp;        // Gated
                o_wr_ready[ch]  <= ch_mask[ch] & i_wr_ready;    // Gated
                o_rd[ch].valid  <= ch_mask[ch] & i_rd.valid;    // Gated
                o_rd[ch].first  <= ch_mask[ch] & i_rd.first;    // Gated
                o_rd[ch].last   <= ch_mask[ch] & i_rd.last;     // Gated
                o_rd[ch].sop    <= i_rd.sop;                    // Broadcast
                o_rd[ch].eop    <= i_rd.eop;                    // Broadcast
                o_rd[ch].data   <= i_rd.data;                   // Broadcast
            end
        end
    end

    always_comb begin
        for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
            rd_valid[ch] = o_rd[ch].valid;
        end
    end

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------
    // Depends on the decoder never flagging a multi-bit enable
    a_valid_onehot0 : assert property (
        @(posedge i_arst) disable iff (i_clk156m)
        $onehot0(rd_valid)
    ) else $error("resp_demux read valid on several channels %h", rd_valid);

endmodule

// ==== src/ddr_port_sel.sv ====
// DDR port selector top level
// Routes one of four front ends (fa04 to fa07) to the shared DDR3 access
// port. The request side goes through three registered multiplexers and the
// response side through a registered fan-out. Every output lags its inputs
// by exactly one clock.

`include "dps_consts.svh"

module ddr_port_sel
    import dps_pkg::*;
(
    input  logic                             i_arst,          // Clock
    input  logic                             i_clk156m,       // Async reset, active high

    // Front-end requests
    input  ddr_cmd_t [`DPS_NUM_CH-1:0]       i_cmd,           // DDR command per channel
    input  st_beat_t [`DPS_NUM_CH-1:0]       i_wr,            // Write beat per channel
    input  logic     [`DPS_NUM_CH-1:0]       i_rd_ready,      // Read FIFO ready per channel

    // Channel enable, one-hot
    input  logic     [`DPS_NUM_CH-1:0]       i_fa_en,

    // Toward the DDR port
    output ddr_cmd_t                         o_cmd,           // Selected command
    output st_beat_t                         o_wr,            // Selected write beat
    output logic                             o_rd_ready,      // Selected read ready

    // From the DDR port
    input  logic                             i_ddr_endp,      // Access complete
    input  logic                             i_ddr_wr_ready,  // Write FIFO ready
    input  st_beat_t                         i_ddr_rd,        // Read beat

    // Front-end responses
    output logic     [`DPS_NUM_CH-1:0]       o_endp,          // Complete per channel
    output logic     [`DPS_NUM_CH-1:0]       o_wr_ready,      // Write ready per channel
    output st_beat_t [`DPS_NUM_CH-1:0]       o_rd             // Read beat per channel
);

    ch_sel_t sel;   // Shared decoded selection

    //------------------------------------------------------------------------
    // Enable decode
    //------------------------------------------------------------------------
    chan_sel u_chan_sel (
        .i_fa_en   (i_fa_en),
        .o_sel     (sel)
    );

    //------------------------------------------------------------------------
    // Request path
    //------------------------------------------------------------------------
    chan_mux #(.T(ddr_cmd_t)) u_cmd_mux (
        .i_arst    (i_arst),
        .i_clk156m (i_clk156m),
        .i_sel     (sel),
        .i_ch      (i_cmd),
        .o_q       (o_cmd)
    );

    chan_mux #(.T(st_beat_t)) u_wr_mux (
        .i_arst    (i_arst),
        .i_clk156m (i_clk156m),
        .i_sel     (sel),
        .i_ch      (i_wr),
        .o_q       (o_wr)
    );

    chan_mux #(.T(logic)) u_rdy_mux (
        .i_arst    (i_arst),
        .i_clk156m (i_clk156m),
        .i_sel     (sel),
        .i_ch      (i_rd_ready),
        .o_q       (o_rd_ready)
    );

    //------------------------------------------------------------------------
    // Response path
    //------------------------------------------------------------------------
    resp_demux u_resp_demux (
        .i_arst     (i_arst),
        .i_clk156m  (i_clk156m),
        .i_sel      (sel),
        .i_endp     (i_ddr_endp),
        .i_wr_ready (i_ddr_wr_ready),
        .i_rd       (i_ddr_rd),
        .o_endp     (o_endp),
        .o_wr_ready (o_wr_ready),
        .o_rd       (o_rd)
    );

endmodule

// ==== bench/tb_ddr_port_sel.sv ====
// DDR port selector testbench
// Drives random requests, responses and channel enables into the selector.
// A reference model predicts every output from the previous cycle's inputs
// and a compare process on the falling edge checks the DUT against it.

`include "dps_consts.svh"

module tb_ddr_port_sel
    import dps_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    //------------------------------------------------------------------------
    // Test lengths and run limit
    //------------------------------------------------------------------------
    localparam int RST_CYC    = 8;                    // Reset hold
    localparam int FLUSH_CYC  = 2;                    // Drain after each test
    localparam int T1_CYC     = RST_CYC + 1 + FLUSH_CYC;
    localparam int T2_CYC     = `DPS_NUM_CH * 6 + FLUSH_CYC;
    localparam int RAND_CYC   = 64;                   // Random tests 3 to 5
    localparam int TOTAL_CYC  = T1_CYC + T2_CYC + 3 * (RAND_CYC + FLUSH_CYC);
    localparam int LIMIT_CYC  = 2 * TOTAL_CYC;

    // Inputs seen before one clock edge
    typedef struct packed {
        logic                           rst;
        logic     [`DPS_NUM_CH-1:0]     fa_en;
        ddr_cmd_t [`DPS_NUM_CH-1:0]     cmd;
        st_beat_t [`DPS_NUM_CH-1:0]     wr;
        logic     [`DPS_NUM_CH-1:0]     rd_ready;
        logic                           ddr_endp;
        logic                           ddr_wr_ready;
        st_beat_t                       ddr_rd;
    } in_snap_t;

    // Outputs expected after that edge
    typedef struct packed {
        ddr_cmd_t                       cmd;
        st_beat_t                       wr;
        logic                           rd_ready;
        logic     [`DPS_NUM_CH-1:0]     endp;
        logic     [`DPS_NUM_CH-1:0]     wr_ready;
        st_beat_t [`DPS_NUM_CH-1:0]     rd;
    } out_exp_t;

    logic                       i_arst;               // Clock
    logic                       i_clk156m;            // Reset
    ddr_cmd_t [`DPS_NUM_CH-1:0] i_cmd;
    st_beat_t [`DPS_NUM_CH-1:0] i_wr;
    logic     [`DPS_NUM_CH-1:0] i_rd_ready;
    logic     [`DPS_NUM_CH-1:0] i_fa_en;
    ddr_cmd_t                   o_cmd;
    st_beat_t                   o_wr;
    logic                       o_rd_ready;
    logic                       i_ddr_endp;
    logic                       i_ddr_wr_ready;
    st_beat_t                   i_ddr_rd;
    logic     [`DPS_NUM_CH-1:0] o_endp;
    logic     [`DPS_NUM_CH-1:0] o_wr_ready;
    st_beat_t [`DPS_NUM_CH-1:0] o_rd;

    integer   seed;                                   // $random state
    int       err_cnt;
    int       chk_cnt;
    int       err_mark;                               // Errors before current test
    int       test_cnt;
    int       cyc_cnt;
    in_snap_t prev_in;                                // Inputs of last cycle
    out_exp_t exp_out;

    ddr_port_sel dut_i (
        .i_arst         (i_arst),
        .i_clk156m      (i_clk156m),
        .i_cmd          (i_cmd),
        .i_wr           (i_wr),
        .i_rd_ready     (i_rd_ready),
        .i_fa_en        (i_fa_en),
        .o_cmd          (o_cmd),
        .o_wr           (o_wr),
        .o_rd_ready     (o_rd_ready),
        .i_ddr_endp     (i_ddr_endp),
        .i_ddr_wr_ready (i_ddr_wr_ready),
        .i_ddr_rd       (i_ddr_rd),
        .o_endp         (o_endp),
        .o_wr_ready     (o_wr_ready),
        .o_rd           (o_rd)
    );

    always #4 i_arst = ~i_arst;                       // 8 ns period

    //------------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------------
    function automatic out_exp_t predict(input in_snap_t s);
        out_exp_t               e;
        logic                   hit;
        logic [`DPS_SEL_W-1:0]  idx;
        e   = '0;
        hit = 1'b0;
        idx = '0;
        if (s.rst) begin
            return e;                                 // Everything low in reset
        end
        for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
            if (s.fa_en == (`DPS_NUM_CH'(1) << ch)) begin
                hit = 1'b1;                           // Exactly this bit
                idx = `DPS_SEL_W'(ch);
            end
            e.rd[ch].sop  = s.ddr_rd.sop;             // Broadcast fields
            e.rd[ch].eop  = s.ddr_rd.eop;
            e.rd[ch].data = s.ddr_rd.data;
        end
        if (hit) begin
            e.cmd            = s.cmd[idx];
            e.wr             = s.wr[idx];
            e.rd_ready       = s.rd_ready[idx];
            e.endp[idx]      = s.ddr_endp;
            e.wr_ready[idx]  = s.ddr_wr_ready;
            e.rd[idx].valid  = s.ddr_rd.valid;
            e.rd[idx].first  = s.ddr_rd.first;
            e.rd[idx].last   = s.ddr_rd.last;
        end
        return e;
    endfunction

    //------------------------------------------------------------------------
    // Compare process, falling edge so inputs and outputs are settled
    //------------------------------------------------------------------------
    task automatic check_outputs(input out_exp_t e);
        chk_cnt++;
        if (o_cmd !== e.cmd) begin
            $display("Error: o_cmd expected %h, got %h", e.cmd, o_cmd);
            err_cnt++;
        end
        if (o_wr !== e.wr) begin
            $display("Error: o_wr expected %h, got %h", e.wr, o_wr);
            err_cnt++;
        end
        if (o_rd_ready !== e.rd_ready) begin
            $display("Error: o_rd_ready expected %h, got %h", e.rd_ready, o_rd_ready);
            err_cnt++;
        end
        if (o_endp !== e.endp) begin
            $display("Error: o_endp expected %h, got %h", e.endp, o_endp);
            err_cnt++;
        end
        if (o_wr_ready !== e.wr_ready) begin
            $display("Error: o_wr_ready expected %h, got %h", e.wr_ready, o_wr_ready);
            err_cnt++;
        end
        for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
            if (o_rd[ch] !== e.rd[ch]) begin
                $display("Error: o_rd[%0d] expected %h, got %h", ch, e.rd[ch], o_rd[ch]);
                err_cnt++;
            end
        end
    endtask

    always @(negedge i_arst) begin
        exp_out = predict(prev_in);
        check_outputs(exp_out);
        prev_in.rst          = i_clk156m;             // Snapshot for next edge
        prev_in.fa_en        = i_fa_en;
        prev_in.cmd          = i_cmd;
        prev_in.wr           = i_wr;
        prev_in.rd_ready     = i_rd_ready;
        prev_in.ddr_endp     = i_ddr_endp;
        prev_in.ddr_wr_ready = i_ddr_wr_ready;
        prev_in.ddr_rd       = i_ddr_rd;
    end

    // Run limit
    always @(posedge i_arst) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= LIMIT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT_CYC);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //------------------------------------------------------------------------
    // Stimulus helpers
    //------------------------------------------------------------------------
    task automatic rand_bits(output logic [159:0] r);
        r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // Random payload on every input, given enable, applied after a clock edge
    task automatic drive_inputs(input logic [`DPS_NUM_CH-1:0] en);
        logic [159:0]               r;
        ddr_cmd_t [`DPS_NUM_CH-1:0] cmd_v;
        st_beat_t [`DPS_NUM_CH-1:0] wr_v;
        for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
            rand_bits(r);
            cmd_v[ch] = r[$bits(ddr_cmd_t)-1:0];
            rand_bits(r);
            wr_v[ch] = r[$bits(st_beat_t)-1:0];
        end
        rand_bits(r);
        i_cmd          <= cmd_v;
        i_wr           <= wr_v;
        i_rd_ready     <= r[`DPS_NUM_CH-1:0];
        i_ddr_endp     <= r[8];
        i_ddr_wr_ready <= r[9];
        rand_bits(r);
        i_ddr_rd       <= r[$bits(st_beat_t)-1:0];
        i_fa_en        <= en;
    endtask

    task automatic finish_test(input string name);
        repeat (FLUSH_CYC) @(posedge i_arst);         // Let last beats be checked
        test_cnt++;
        $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    //------------------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------------------
    initial begin
        logic [159:0]           r;
        logic [`DPS_NUM_CH-1:0] en;
        int                     ch_cur;
        int                     step;
        seed           = 41;
        err_cnt        = 0;
        chk_cnt        = 0;
        err_mark       = 0;
        test_cnt       = 0;
        cyc_cnt        = 0;
        i_arst         = 1'b0;
        i_clk156m      = 1'b1;
        i_cmd          = '0;
        i_wr           = '0;
        i_rd_ready     = '0;
        i_fa_en        = '0;
        i_ddr_endp     = 1'b0;
        i_ddr_wr_ready = 1'b0;
        i_ddr_rd       = '0;
        prev_in        = '0;
        prev_in.rst    = 1'b1;                        // Outputs start in reset

        // 1: busy inputs during reset, all outputs stay low
        for (int i = 0; i < RST_CYC; i++) begin
            rand_bits(r);
            @(posedge i_arst);
            drive_inputs(r[`DPS_NUM_CH-1:0]);
            if (i == RST_CYC - 1) begin
                i_clk156m <= 1'b0;                    // Release on 8th edge
            end
        end
        @(posedge i_arst);
        finish_test("reset");

        // 2: each one-hot enable held for a few cycles
        for (int ch = 0; ch < `DPS_NUM_CH; ch++) begin
            repeat (6) begin
                @(posedge i_arst);
                drive_inputs(`DPS_NUM_CH'(1) << ch);
            end
        end
        finish_test("one-hot command");

        // 3: channel hops on every cycle
        ch_cur = 0;
        repeat (RAND_CYC) begin
            rand_bits(r);
            step   = 1 + int'(r[7:0]) % 3;            // Never the same channel
            ch_cur = (ch_cur + step) % `DPS_NUM_CH;
            @(posedge i_arst);
            drive_inputs(`DPS_NUM_CH'(1) << ch_cur);
        end
        finish_test("write hopping");

        // 4: random one-hot with random responses
        repeat (RAND_CYC) begin
            rand_bits(r);
            ch_cur = int'(r[7:0]) % `DPS_NUM_CH;
            @(posedge i_arst);
            drive_inputs(`DPS_NUM_CH'(1) << ch_cur);
        end
        finish_test("response routing");

        // 5: zero or multi-bit enables only
        for (int i = 0; i < RAND_CYC; i++) begin
            rand_bits(r);
            en = r[`DPS_NUM_CH-1:0];
            if ($onehot(en)) begin
                en = ~en;                             // Three bits set
            end
            if (i % 4 == 0) begin
                en = '0;
            end
            @(posedge i_arst);
            drive_inputs(en);
        end
        finish_test("no selection");

        $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/dps_pkg.sv
src/chan_sel.sv
src/chan_mux.sv
src/resp_demux.sv
src/ddr_port_sel.sv
bench/tb_ddr_port_sel.sv

// ==== Makefile ====
# Verilator build and run for the DDR port selector

VERILATOR ?= verilator
TOP       ?= tb_ddr_port_sel
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)
